/* Makefile */
SIM      := verilator
FLAGS    := --binary --timing --assert -j 0
TOP      := mmio_afu_tb
FILELIST := verilog.f

OBJ_DIR  := obj_dir
BIN      := $(OBJ_DIR)/V$(TOP)
LOG      := sim.log
PASS_MSG := PASS: all tests
SOURCES  := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1; cat $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* logic/host_chan_mmio_adapter.sv */
`timescale 1ns/1ps
`default_nettype none

module host_chan_mmio_adapter #(
    parameter int TIMING_STAGES = 2
) (
    input  logic                             clk,
    input  logic                             rst,
    input  logic                             req_req,
    input  mmio_afu_pkg::host_req_t          host_req,
    output logic                             req_ack,
    output logic                             rsp_req,
    output mmio_afu_pkg::host_rsp_t          rsp,
    input  logic                             rsp_ack,
    output mmio_afu_pkg::mmio64_req_t        mmio64,
    output mmio_afu_pkg::mmio512_req_t       mmio512,
    input  logic [mmio_afu_pkg::QWORD_W-1:0] rd_data
);
    import mmio_afu_pkg::*;

    logic accept;
    logic read_pending;
    logic rd_wait;
    logic rsp_drop;
    host_req_t tail_req;
    logic tail_vld;
    logic [QWORD_ADDR_W-1:0] line_off;
    logic line_ok;
    logic to_line;

    // ============================================================
    // Request handshake
    // ============================================================

    // A new request is taken only between handshakes and never while
    // a read is still waiting for its response to complete
    assign accept = req_req && !req_ack && !read_pending;

    // The ack stays up until the host withdraws its request
    always_ff @(posedge clk) begin
        if (rst) begin
            req_ack <= 1'b0;
        end else if (accept) begin
            req_ack <= 1'b1;
        end else if (!req_req) begin
            req_ack <= 1'b0;
        end
    end

    // ============================================================
    // Timing register stages
    // ============================================================

    if (TIMING_STAGES == 0) begin : g_no_stage
        // Without stages the strobe register takes the request directly
        assign tail_vld = accept;
        assign tail_req = host_req;
    end else begin : g_stages
        host_req_t pipe_req [TIMING_STAGES];
        logic [TIMING_STAGES-1:0] pipe_vld;

        // Stage 0 is the capture register and loads with the ack
        always_ff @(posedge clk) begin
            pipe_req[0] <= host_req;
            for (int i = 1; i < TIMING_STAGES; i++) begin
                pipe_req[i] <= pipe_req[i-1];
            end
            if (rst) begin
                pipe_vld <= '0;
            end else begin
                pipe_vld[0] <= accept;
                for (int i = 1; i < TIMING_STAGES; i++) begin
                    pipe_vld[i] <= pipe_vld[i-1];
                end
            end
        end

        assign tail_vld = pipe_vld[TIMING_STAGES-1];
        assign tail_req = pipe_req[TIMING_STAGES-1];
    end

    // ============================================================
    // Strobe steering
    // ============================================================

    // Offset into the line window and the alignment rule for line writes
    assign line_off = tail_req.address - LINE_BASE;
    assign line_ok = (tail_req.address >= LINE_BASE) &&
                     (line_off < QWORD_ADDR_W'(LINE_QWORDS)) &&
                     (line_off[QWORD_SEL_W-1:0] == '0);

    // Reads always go out on the 64-bit port since the line port has no read side
    assign to_line = tail_req.is_write && tail_req.is_line;

    always_ff @(posedge clk) begin
        mmio64.write <= tail_req.is_write;
        mmio64.address <= tail_req.address;
        mmio64.data <= tail_req.payload.qword[0];
        mmio512.line <= line_off[QWORD_SEL_W +: LINE_IDX_W];
        mmio512.data <= tail_req.payload;
        if (rst) begin
            mmio64.valid <= 1'b0;
            mmio512.valid <= 1'b0;
        end else begin
            mmio64.valid <= tail_vld && !to_line;
            // A misplaced line write is simply dropped here
            mmio512.valid <= tail_vld && to_line && line_ok;
        end
    end

    // ============================================================
    // Read response handshake
    // ============================================================

    always_ff @(posedge clk) begin
        // The address is kept from the strobe and the data arrives a cycle later
        if (mmio64.valid && !mmio64.write) begin
            rsp.address <= mmio64.address;
        end
        if (rd_wait) begin
            rsp.data <= rd_data;
        end
        if (rst) begin
            read_pending <= 1'b0;
            rd_wait <= 1'b0;
            rsp_req <= 1'b0;
            rsp_drop <= 1'b0;
        end else begin
            rd_wait <= mmio64.valid && !mmio64.write;

            // Pending covers the whole trip from ack to the end of the response
            if (accept && !host_req.is_write) begin
                read_pending <= 1'b1;
            end else if (rsp_drop && !rsp_ack) begin
                read_pending <= 1'b0;
            end

            if (rd_wait) begin
                rsp_req <= 1'b1;
            end else if (rsp_req && rsp_ack) begin
                rsp_req <= 1'b0;
            end

            // Wait for the host to release its ack before the next request
            if (rsp_req && rsp_ack) begin
                rsp_drop <= 1'b1;
            end else if (!rsp_ack) begin
                rsp_drop <= 1'b0;
            end
        end
    end

    // No request is acked while a read is still on its way through the
    // strobe, the read data register or the response handshake
    a_no_ack_during_read: assert property (@(posedge clk) disable iff (rst)
        $rose(req_ack) |->
            !$past(mmio64.valid && !mmio64.write) && !$past(rd_wait) &&
            !$past(rsp_req) && !$past(rsp_drop));

    // The response is held for as long as it is offered
    a_rsp_stable: assert property (@(posedge clk) disable iff (rst)
        rsp_req && $past(rsp_req) |-> rsp == $past(rsp));

endmodule

`default_nettype wire

/* logic/mmio_afu_pkg.sv */
`default_nettype none

package mmio_afu_pkg;

    // ============================================================
    // Sizes and address map
    // ============================================================

    // Every MMIO address on the host channel counts 64-bit qwords
    localparam int QWORD_ADDR_W = 12;
    localparam int QWORD_W = 64;
    localparam int LINE_W = 512;

    // One line holds eight qwords, so three address bits pick the lane
    localparam int QWORDS_PER_LINE = LINE_W / QWORD_W;
    localparam int QWORD_SEL_W = 3;

    // Register 0 is the identifier and the rest are scratch
    localparam int NUM_CSR = 16;
    localparam int CSR_IDX_W = 4;
    localparam logic [QWORD_W-1:0] AFU_ID = 64'h5a3c_96e1_0f27_b4d8;

    // The line window sits above the register region
    localparam logic [QWORD_ADDR_W-1:0] LINE_BASE = 12'h100;
    localparam int NUM_LINES = 4;
    localparam int LINE_IDX_W = 2;
    localparam int LINE_QWORDS = NUM_LINES * QWORDS_PER_LINE;
    localparam int LINE_QW_IDX_W = 5;

    // ============================================================
    // Payload and request types
    // ============================================================

    // The same 512 bits seen either as a whole line or as eight lanes
    typedef union packed {
        logic [LINE_W-1:0] line;
        logic [QWORDS_PER_LINE-1:0][QWORD_W-1:0] qword;
    } mmio_payload_u;

    // One request as the host presents it
    // A 64-bit access carries its data in lane 0 of the payload
    typedef struct packed {
        logic is_write;
        logic is_line;
        logic [QWORD_ADDR_W-1:0] address;
        mmio_payload_u payload;
    } host_req_t;

    // Read response returned to the host
    typedef struct packed {
        logic [QWORD_ADDR_W-1:0] address;
        logic [QWORD_W-1:0] data;
    } host_rsp_t;

    // Single-cycle strobe on the 64-bit read/write port
    typedef struct packed {
        logic valid;
        logic write;
        logic [QWORD_ADDR_W-1:0] address;
        logic [QWORD_W-1:0] data;
    } mmio64_req_t;

    // Single-cycle strobe on the write-only line port
    typedef struct packed {
        logic valid;
        logic [LINE_IDX_W-1:0] line;
        mmio_payload_u data;
    } mmio512_req_t;

endpackage

`default_nettype wire

/* logic/mmio_afu_top.sv */
`timescale 1ns/1ps
`default_nettype none

module mmio_afu_top (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    req_req,
    input  mmio_afu_pkg::host_req_t host_req,
    output logic                    req_ack,
    output logic                    rsp_req,
    output mmio_afu_pkg::host_rsp_t rsp,
    input  logic                    rsp_ack
);
    import mmio_afu_pkg::*;

    // Strobes and read data between the host shim and the accelerator
    mmio64_req_t mmio64;
    mmio512_req_t mmio512;
    logic [QWORD_W-1:0] rd_data;

    // Host channel split into the two MMIO ports
    host_chan_mmio_adapter #(
        .TIMING_STAGES (2)
    ) chan_adapter (
        .clk      (clk),
        .rst      (rst),
        .req_req  (req_req),
        .host_req (host_req),
        .req_ack  (req_ack),
        .rsp_req  (rsp_req),
        .rsp      (rsp),
        .rsp_ack  (rsp_ack),
        .mmio64   (mmio64),
        .mmio512  (mmio512),
        .rd_data  (rd_data)
    );

    mmio_test_afu afu (
        .clk     (clk),
        .rst     (rst),
        .mmio64  (mmio64),
        .mmio512 (mmio512),
        .rd_data (rd_data)
    );

endmodule

`default_nettype wire

/* logic/mmio_csr_regs.sv */
`timescale 1ns/1ps
`default_nettype none

module mmio_csr_regs (
    input  logic                               clk,
    input  logic                               rst,
    input  logic                               wr_en,
    input  logic                               rd_en,
    input  logic [mmio_afu_pkg::CSR_IDX_W-1:0] index,
    input  logic [mmio_afu_pkg::QWORD_W-1:0]   wr_data,
    output logic [mmio_afu_pkg::QWORD_W-1:0]   rd_data
);
    import mmio_afu_pkg::*;

    // Only the scratch registers have storage because index 0 reads the identifier
    logic [QWORD_W-1:0] scratch [1:NUM_CSR-1];
    logic id_sel;

    assign id_sel = (index == '0);

    // ============================================================
    // Scratch storage
    // ============================================================

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 1; i < NUM_CSR; i++) begin
                scratch[i] <= '0;
            end
        end else if (wr_en && !id_sel) begin
            // Writes to the identifier slot fall through without effect
            scratch[index] <= wr_data;
        end
    end

    // ============================================================
    // Read port
    // ============================================================

    // Read data is held until the next read of this block
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_data <= id_sel ? AFU_ID : scratch[index];
        end
    end

endmodule

`default_nettype wire

/* logic/mmio_line_store.sv */
`timescale 1ns/1ps
`default_nettype none

module mmio_line_store (
    input  logic                                   clk,
    input  logic                                   rst,
    input  mmio_afu_pkg::mmio512_req_t             line_wr,
    input  logic                                   qword_wr_en,
    input  logic                                   rd_en,
    input  logic [mmio_afu_pkg::LINE_QW_IDX_W-1:0] qword_index,
    input  logic [mmio_afu_pkg::QWORD_W-1:0]       qword_data,
    output logic [mmio_afu_pkg::QWORD_W-1:0]       rd_data
);
    import mmio_afu_pkg::*;

    mmio_payload_u lines [NUM_LINES];
    logic [LINE_IDX_W-1:0] qw_line;
    logic [QWORD_SEL_W-1:0] qw_lane;

    // Upper bits of the window offset pick the line and the low bits the lane
    assign qw_line = qword_index[QWORD_SEL_W +: LINE_IDX_W];
    assign qw_lane = qword_index[QWORD_SEL_W-1:0];

    // ============================================================
    // Line and lane writes
    // ============================================================

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < NUM_LINES; i++) begin
                lines[i].line <= '0;
            end
        end else begin
            // A full line write replaces every lane at once
            if (line_wr.valid) begin
                lines[line_wr.line] <= line_wr.data;
            end
            // A qword write touches one lane and leaves its neighbours alone
            if (qword_wr_en) begin
                lines[qw_line].qword[qw_lane] <= qword_data;
            end
        end
    end

    // ============================================================
    // Lane read
    // ============================================================

    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_data <= lines[qw_line].qword[qw_lane];
        end
    end

    // The adapter issues at most one strobe per cycle across both ports
    a_one_writer: assert property (@(posedge clk) disable iff (rst)
        !(line_wr.valid && qword_wr_en));

endmodule

`default_nettype wire

/* logic/mmio_test_afu.sv */
`timescale 1ns/1ps
`default_nettype none

module mmio_test_afu (
    input  logic                             clk,
    input  logic                             rst,
    input  mmio_afu_pkg::mmio64_req_t        mmio64,
    input  mmio_afu_pkg::mmio512_req_t       mmio512,
    output logic [mmio_afu_pkg::QWORD_W-1:0] rd_data
);
    import mmio_afu_pkg::*;

    logic hit_csr;
    logic hit_line;
    logic [QWORD_ADDR_W-1:0] line_off;
    logic rd_strobe;
    logic wr_strobe;
    logic sel_csr;
    logic sel_line;
    logic [QWORD_W-1:0] csr_rd_data;
    logic [QWORD_W-1:0] line_rd_data;

    // ============================================================
    // Address decode
    // ============================================================

    // Registers sit at the bottom of the map
    assign hit_csr = (mmio64.address < QWORD_ADDR_W'(NUM_CSR));

    // The line window spans LINE_QWORDS qwords from LINE_BASE
    assign line_off = mmio64.address - LINE_BASE;
    assign hit_line = (mmio64.address >= LINE_BASE) &&
                      (line_off < QWORD_ADDR_W'(LINE_QWORDS));

    assign rd_strobe = mmio64.valid && !mmio64.write;
    assign wr_strobe = mmio64.valid && mmio64.write;

    // Remember where the last read went so its data can be picked next cycle
    always_ff @(posedge clk) begin
        if (rst) begin
            sel_csr <= 1'b0;
            sel_line <= 1'b0;
        end else if (rd_strobe) begin
            sel_csr <= hit_csr;
            sel_line <= hit_line;
        end
    end

    // Unmapped reads come back as zero
    assign rd_data = sel_csr  ? csr_rd_data :
                     sel_line ? line_rd_data : '0;

    // ============================================================
    // Storage blocks
    // ============================================================

    mmio_csr_regs csr (
        .clk     (clk),
        .rst     (rst),
        .wr_en   (wr_strobe && hit_csr),
        .rd_en   (rd_strobe && hit_csr),
        .index   (mmio64.address[CSR_IDX_W-1:0]),
        .wr_data (mmio64.data),
        .rd_data (csr_rd_data)
    );

    mmio_line_store line_store (
        .clk         (clk),
        .rst         (rst),
        .line_wr     (mmio512),
        .qword_wr_en (wr_strobe && hit_line),
        .rd_en       (rd_strobe && hit_line),
        .qword_index (line_off[LINE_QW_IDX_W-1:0]),
        .qword_data  (mmio64.data),
        .rd_data     (line_rd_data)
    );

endmodule

`default_nettype wire

/* test/mmio_afu_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module mmio_afu_tb;
    import mmio_afu_pkg::*;

    // Longest wait in clock cycles for any single handshake edge
    localparam int TIMEOUT = 200;

    logic clk;
    logic rst;
    logic req_req;
    host_req_t host_req;
    logic req_ack;
    logic rsp_req;
    host_rsp_t rsp;
    logic rsp_ack;

    integer seed;
    int n_checks;
    int n_errors;
    int n_tests;
    int n_tests_failed;
    int test_start_errors;

    // Reference copies of the register file and the line store
    logic [QWORD_W-1:0] csr_m [NUM_CSR];
    mmio_payload_u line_m [NUM_LINES];

    mmio_afu_top UUT (
        .clk      (clk),
        .rst      (rst),
        .req_req  (req_req),
        .host_req (host_req),
        .req_ack  (req_ack),
        .rsp_req  (rsp_req),
        .rsp      (rsp),
        .rsp_ack  (rsp_ack)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // ============================================================
    // Reference model
    // ============================================================

    function automatic logic in_window(input logic [QWORD_ADDR_W-1:0] addr);
        return (addr >= LINE_BASE) && (int'(addr) < int'(LINE_BASE) + LINE_QWORDS);
    endfunction

    function automatic logic [QWORD_W-1:0] model_read(input logic [QWORD_ADDR_W-1:0] addr);
        logic [QWORD_ADDR_W-1:0] off;
        off = addr - LINE_BASE;
        if (addr == '0) begin
            return AFU_ID;
        end
        if (int'(addr) < NUM_CSR) begin
            return csr_m[addr[CSR_IDX_W-1:0]];
        end
        // Line L covers LINE_BASE+8L up to LINE_BASE+8L+7
        if (in_window(addr)) begin
            return line_m[LINE_IDX_W'(off / 8)].qword[QWORD_SEL_W'(off % 8)];
        end
        return '0;
    endfunction

    function automatic void model_write_qword(input logic [QWORD_ADDR_W-1:0] addr,
                                              input logic [QWORD_W-1:0] data);
        logic [QWORD_ADDR_W-1:0] off;
        off = addr - LINE_BASE;
        if (addr != '0 && int'(addr) < NUM_CSR) begin
            csr_m[addr[CSR_IDX_W-1:0]] = data;
        end else if (in_window(addr)) begin
            line_m[LINE_IDX_W'(off / 8)].qword[QWORD_SEL_W'(off % 8)] = data;
        end
    endfunction

    // Only a line write that starts a line inside the window lands
    function automatic void model_write_line(input logic [QWORD_ADDR_W-1:0] addr,
                                             input mmio_payload_u data);
        logic [QWORD_ADDR_W-1:0] off;
        off = addr - LINE_BASE;
        if (in_window(addr) && (off % 8) == 0) begin
            line_m[LINE_IDX_W'(off / 8)] = data;
        end
    endfunction

    // ============================================================
    // Random values
    // ============================================================

    function automatic logic [QWORD_W-1:0] rand64();
        return {$random(seed), $random(seed)};
    endfunction

    function automatic mmio_payload_u rand_line();
        mmio_payload_u p;
        for (int i = 0; i < QWORDS_PER_LINE; i++) begin
            p.qword[i] = rand64();
        end
        return p;
    endfunction

    // Unmapped space is the gap above the registers and everything past the window
    function automatic logic [QWORD_ADDR_W-1:0] pick_unmapped_addr();
        if ({$random(seed)} % 2 == 0) begin
            return QWORD_ADDR_W'(NUM_CSR + {$random(seed)} % (int'(LINE_BASE) - NUM_CSR));
        end
        return QWORD_ADDR_W'(int'(LINE_BASE) + LINE_QWORDS +
                             {$random(seed)} % (4096 - int'(LINE_BASE) - LINE_QWORDS));
    endfunction

    function automatic logic [QWORD_ADDR_W-1:0] pick_any_addr();
        case ({$random(seed)} % 3)
            0: return QWORD_ADDR_W'({$random(seed)} % NUM_CSR);
            1: return QWORD_ADDR_W'(int'(LINE_BASE) + {$random(seed)} % LINE_QWORDS);
            default: return pick_unmapped_addr();
        endcase
    endfunction

    function automatic logic [QWORD_ADDR_W-1:0] pick_line_addr();
        return QWORD_ADDR_W'(int'(LINE_BASE) + 8 * ({$random(seed)} % NUM_LINES));
    endfunction

    // ============================================================
    // Handshake helpers
    // ============================================================

    task automatic report_stall(input string what);
        $display("Timeout: the DUT stalled while the testbench waited for %s", what);
        $display("FAIL: see errors above");
        $finish;
    endtask

    // Outputs are sampled on the falling edge, away from the driving edge
    task automatic wait_req_ack(input logic level, input string what);
        int n;
        n = 0;
        @(negedge clk);
        while (req_ack !== level && n < TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (req_ack !== level) begin
            report_stall(what);
        end
    endtask

    task automatic wait_rsp_req(input logic level, input string what);
        int n;
        n = 0;
        @(negedge clk);
        while (rsp_req !== level && n < TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (rsp_req !== level) begin
            report_stall(what);
        end
    endtask

    task automatic check_value(input string what, input logic [QWORD_W-1:0] got,
                               input logic [QWORD_W-1:0] exp);
        n_checks++;
        assert (got === exp) else begin
            $display("FAIL %0d ns: %s got %h expected %h", $time, what, got, exp);
            n_errors++;
        end
    endtask

    // Full four-phase request cycle
    task automatic send_req(input host_req_t r);
        @(posedge clk);
        host_req <= r;
        req_req <= 1'b1;
        wait_req_ack(1'b1, "req_ack to rise");
        @(posedge clk);
        req_req <= 1'b0;
        wait_req_ack(1'b0, "req_ack to fall");
    endtask

    // The response is taken as offered and the ack is sometimes held back
    task automatic take_rsp(input logic [QWORD_ADDR_W-1:0] addr,
                            input logic [QWORD_W-1:0] exp);
        host_rsp_t got;
        int delay;
        wait_rsp_req(1'b1, "rsp_req to rise");
        got = rsp;
        delay = ($random(seed) & 1) ? ({$random(seed)} % 8) : 0;
        repeat (delay) @(negedge clk);
        // While the ack is held back the response stays on offer unchanged
        n_checks++;
        assert (rsp_req === 1'b1 && rsp === got) else begin
            $display("FAIL %0d ns: response for 0x%03h changed while rsp_ack was held low",
                     $time, addr);
            n_errors++;
        end
        @(posedge clk);
        rsp_ack <= 1'b1;
        wait_rsp_req(1'b0, "rsp_req to fall");
        @(posedge clk);
        rsp_ack <= 1'b0;
        check_value($sformatf("response address for 0x%03h", addr),
                    QWORD_W'(got.address), QWORD_W'(addr));
        check_value($sformatf("read 0x%03h", addr), got.data, exp);
    endtask

    // ============================================================
    // Bus operations
    // ============================================================

    task automatic read_check(input logic [QWORD_ADDR_W-1:0] addr);
        host_req_t r;
        r.is_write = 1'b0;
        r.is_line = 1'b0;
        r.address = addr;
        r.payload = rand_line();
        send_req(r);
        take_rsp(addr, model_read(addr));
    endtask

    task automatic write_qword(input logic [QWORD_ADDR_W-1:0] addr,
                               input logic [QWORD_W-1:0] data);
        host_req_t r;
        r.is_write = 1'b1;
        r.is_line = 1'b0;
        r.address = addr;
        // Lanes above 0 carry junk that the DUT has to ignore
        r.payload = rand_line();
        r.payload.qword[0] = data;
        send_req(r);
        model_write_qword(addr, data);
    endtask

    task automatic write_line(input logic [QWORD_ADDR_W-1:0] addr,
                              input mmio_payload_u data);
        host_req_t r;
        r.is_write = 1'b1;
        r.is_line = 1'b1;
        r.address = addr;
        r.payload = data;
        send_req(r);
        model_write_line(addr, data);
    endtask

    task automatic check_lines();
        for (int i = 0; i < LINE_QWORDS; i++) begin
            read_check(QWORD_ADDR_W'(int'(LINE_BASE) + i));
        end
    endtask

    task automatic check_all();
        for (int i = 0; i < NUM_CSR; i++) begin
            read_check(QWORD_ADDR_W'(i));
        end
        check_lines();
    endtask

    task automatic end_test(input string name);
        n_tests++;
        if (n_errors == test_start_errors) begin
            $display("test %0d %s: ok", n_tests, name);
        end else begin
            n_tests_failed++;
            $display("test %0d %s: %0d errors", n_tests, name, n_errors - test_start_errors);
        end
        test_start_errors = n_errors;
    endtask

    // ============================================================
    // Test sequence
    // ============================================================

    initial begin
        logic [QWORD_ADDR_W-1:0] addr;
        seed = 32'h3ea4;
        n_checks = 0;
        n_errors = 0;
        n_tests = 0;
        n_tests_failed = 0;
        test_start_errors = 0;
        rst <= 1'b1;
        req_req <= 1'b0;
        host_req <= '0;
        rsp_ack <= 1'b0;
        for (int i = 0; i < NUM_CSR; i++) begin
            csr_m[i] = '0;
        end
        for (int i = 0; i < NUM_LINES; i++) begin
            line_m[i].line = '0;
        end
        repeat (10) @(posedge clk);
        rst <= 1'b0;

        check_all();
        end_test("after_reset");

        for (int i = 0; i < 40; i++) begin
            addr = QWORD_ADDR_W'(1 + {$random(seed)} % (NUM_CSR - 1));
            if ($random(seed) & 1) begin
                write_qword(addr, rand64());
            end else begin
                read_check(addr);
            end
        end
        // The identifier slot ignores writes
        write_qword('0, rand64());
        read_check('0);
        end_test("scratch_regs");

        for (int i = 0; i < 8; i++) begin
            write_line(pick_line_addr(), rand_line());
        end
        check_lines();
        for (int i = 0; i < 6; i++) begin
            write_line(pick_line_addr() + QWORD_ADDR_W'(1 + {$random(seed)} % 7), rand_line());
            write_line(pick_unmapped_addr() & 12'hff8, rand_line());
        end
        write_line(QWORD_ADDR_W'(8), rand_line());
        check_all();
        end_test("line_writes");

        for (int i = 0; i < 6; i++) begin
            addr = QWORD_ADDR_W'(int'(LINE_BASE) + {$random(seed)} % LINE_QWORDS);
            write_qword(addr, rand64());
            for (int j = 0; j < QWORDS_PER_LINE; j++) begin
                read_check((addr & 12'hff8) + QWORD_ADDR_W'(j));
            end
        end
        end_test("lane_updates");

        for (int i = 0; i < 10; i++) begin
            read_check(pick_unmapped_addr());
            write_qword(pick_unmapped_addr(), rand64());
        end
        check_all();
        end_test("unmapped");

        // Writes go back to back while reads hold the channel until answered
        for (int i = 0; i < 80; i++) begin
            case ({$random(seed)} % 4)
                0: write_qword(pick_any_addr(), rand64());
                1: write_line(pick_line_addr(), rand_line());
                default: read_check(pick_any_addr());
            endcase
        end
        check_all();
        end_test("mixed_traffic");

        $display("tests run %0d, tests failed %0d, checks %0d, errors %0d",
                 n_tests, n_tests_failed, n_checks, n_errors);
        if (n_errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* verilog.f */
logic/mmio_afu_pkg.sv
logic/host_chan_mmio_adapter.sv
logic/mmio_csr_regs.sv
logic/mmio_line_store.sv
logic/mmio_test_afu.sv
logic/mmio_afu_top.sv
test/mmio_afu_tb.sv
